//--- include/sine_table.svh
// quarter-wave sine table, entry k is round(4096*sin(2*pi*k/256))
// indexed by angle bits 11:4 once folded into the first quadrant
localparam int SINE_TABLE [0:64] = '{
	   0,  101,  201,  301,  401,  501,  601,  700,  799,  897,
	 995, 1092, 1189, 1285, 1380, 1474, 1567, 1660, 1751, 1842,
	1931, 2019, 2106, 2191, 2276, 2359, 2440, 2520, 2598, 2675,
	2751, 2824, 2896, 2967, 3035, 3102, 3166, 3229, 3290, 3349,
	3406, 3461, 3513, 3564, 3612, 3659, 3703, 3745, 3784, 3822,
	3857, 3889, 3920, 3948, 3973, 3996, 4017, 4036, 4052, 4065,
	4076, 4085, 4091, 4095, 4096
};

//--- src/ik_pkg.sv
// IK step engine package
// Q11.12 fixed-point types, angle type, matrix structs and the product rule
`default_nettype none

package ik_pkg;

	localparam int FRAC = 12;

	typedef logic signed [23:0] fx_t; // Q11.12
	typedef logic [11:0] angle_t;     // 4096 per turn, wraps

	typedef struct packed {
		fx_t x;
		fx_t y;
	} vec2_t;

	// vectors ride in column 0 with column 1 zero
	typedef struct packed {
		fx_t m00;
		fx_t m01;
		fx_t m10;
		fx_t m11;
	} mat2_t;

	typedef struct packed {
		angle_t t1;
		angle_t t2;
	} joint_angles_t;

	typedef struct packed {
		fx_t s1;
		fx_t c1;
		fx_t s12; // sin(t1 + t2)
		fx_t c12;
	} trig_t;

	localparam fx_t RAD_TO_ANG = 24'sd652; // angle units per radian

	// full product, floor shift by FRAC, wrap to 24 bits
	function automatic fx_t fx_mul(input fx_t a, input fx_t b);
		logic signed [47:0] p;
		p = a * b;
		return fx_t'(p >>> FRAC);
	endfunction

endpackage

`default_nettype wire

//--- src/sincos_lut.sv
// sine/cosine lookup for t1 and t1+t2
// folds each angle onto the quarter-wave table, one registered stage
`default_nettype none

module sincos_lut (
	input wire logic i,
	input wire logic i_arst_n,
	input wire ik_pkg::joint_angles_t i_theta,
	output ik_pkg::trig_t o_trig
);
	import ik_pkg::*;

	`include "sine_table.svh"

	angle_t theta12;

	// quadrant fold, 65..127 mirror around 64, upper half negated
	function automatic fx_t sin_lookup(input angle_t a);
		logic [7:0] n;
		logic [6:0] m;
		fx_t v;
		n = a[11:4];
		m = (n[6:0] <= 7'd64) ? n[6:0] : 7'(8'd128 - {1'b0, n[6:0]});
		v = fx_t'(SINE_TABLE[m]);
		return n[7] ? -v : v;
	endfunction

	assign theta12 = i_theta.t1 + i_theta.t2; // mod 4096

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_trig <= '0;
		end else begin
			o_trig.s1 <= sin_lookup(i_theta.t1);
			o_trig.c1 <= sin_lookup(i_theta.t1 + 12'd1024); // cos = sin(a + quarter)
			o_trig.s12 <= sin_lookup(theta12);
			o_trig.c12 <= sin_lookup(theta12 + 12'd1024);
		end
	end

endmodule

`default_nettype wire

//--- src/arm_kinematics.sv
// forward kinematics of the planar two-link arm
// end-effector position and 2x2 Jacobian, registered
`default_nettype none

module arm_kinematics #(
	parameter ik_pkg::fx_t LINK1 = 24'sd4096,
	parameter ik_pkg::fx_t LINK2 = 24'sd3072
) (
	input wire logic i,
	input wire logic i_arst_n,
	input wire ik_pkg::trig_t i_trig,
	output ik_pkg::vec2_t o_pos,
	output ik_pkg::mat2_t o_jac
);
	import ik_pkg::*;

	fx_t l1_c1;
	fx_t l1_s1;
	fx_t l2_c12;
	fx_t l2_s12;
	fx_t pos_x;
	fx_t pos_y;

	assign l1_c1 = fx_mul(LINK1, i_trig.c1);
	assign l1_s1 = fx_mul(LINK1, i_trig.s1);
	assign l2_c12 = fx_mul(LINK2, i_trig.c12);
	assign l2_s12 = fx_mul(LINK2, i_trig.s12);

	assign pos_x = l1_c1 + l2_c12;
	assign pos_y = l1_s1 + l2_s12;

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_pos <= '0;
			o_jac <= '0;
		end else begin
			o_pos.x <= pos_x;
			o_pos.y <= pos_y;
			// row 0 is d(x)/d(t1,t2), row 1 is d(y)/d(t1,t2)
			o_jac.m00 <= -pos_y; // -L1s1 - L2s12
			o_jac.m01 <= -l2_s12;
			o_jac.m10 <= pos_x;
			o_jac.m11 <= l2_c12;
		end
	end

endmodule

`default_nettype wire

//--- src/mat_mult2.sv
// 2x2 fixed-point matrix multiplier, one registered stage
// shared by the J*J', inverse*e and J'*w phases
`default_nettype none

module mat_mult2 (
	input wire logic i,
	input wire logic i_arst_n,
	input wire logic i_check,
	input wire ik_pkg::mat2_t i_a,
	input wire ik_pkg::mat2_t i_b,
	output ik_pkg::mat2_t o_p
);
	import ik_pkg::*;

	logic signed [24:0] s00;
	logic signed [24:0] s01;
	logic signed [24:0] s10;
	logic signed [24:0] s11;
	logic ovf;

	// one extra bit so the wrap can be seen
	function automatic logic signed [24:0] dot2(
		input fx_t a0,
		input fx_t b0,
		input fx_t a1,
		input fx_t b1
	);
		fx_t p0;
		fx_t p1;
		p0 = fx_mul(a0, b0);
		p1 = fx_mul(a1, b1);
		return {p0[23], p0} + {p1[23], p1};
	endfunction

	assign s00 = dot2(i_a.m00, i_b.m00, i_a.m01, i_b.m10);
	assign s01 = dot2(i_a.m00, i_b.m01, i_a.m01, i_b.m11);
	assign s10 = dot2(i_a.m10, i_b.m00, i_a.m11, i_b.m10);
	assign s11 = dot2(i_a.m10, i_b.m01, i_a.m11, i_b.m11);

	assign ovf = (s00[24] != s00[23]) || (s01[24] != s01[23]) ||
		(s10[24] != s10[23]) || (s11[24] != s11[23]);

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_p <= '0;
		end else begin
			o_p.m00 <= s00[23:0]; // wrapped sums
			o_p.m01 <= s01[23:0];
			o_p.m10 <= s10[23:0];
			o_p.m11 <= s11[23:0];
		end
	end

	// solve results are only meaningful if no entry wrapped
	assert property (@(posedge i) disable iff (!i_arst_n) i_check |-> !ovf)
		else $error("mat_mult2: entry sum overflow in solve phase");

endmodule

`default_nettype wire

//--- src/recip_div.sv
// sequential restoring divider, quotient of 2^24 over a positive divisor
// one quotient bit per cycle, 25 iterations, first one on the start edge
`default_nettype none

module recip_div (
	input wire logic i,
	input wire logic i_arst_n,
	input wire logic i_start,
	input wire ik_pkg::fx_t i_divisor,
	output logic o_busy,
	output logic o_done,
	output ik_pkg::fx_t o_quot
);
	import ik_pkg::*;

	localparam int ITERS = 25;

	logic busy_q;
	logic done_q;
	logic [4:0] cnt_q;
	logic [24:0] rem_q;
	logic [24:0] quot_q;
	fx_t div_q;
	logic first;
	fx_t div_sel;
	logic [25:0] step; // {quotient bit, remainder}

	// shift in one dividend bit, subtract if it fits
	function automatic logic [25:0] div_step(
		input logic [24:0] r,
		input logic b,
		input fx_t d
	);
		logic [24:0] t;
		t = {r[23:0], b};
		if (t >= {1'b0, d}) begin
			return {1'b1, t - {1'b0, d}};
		end
		return {1'b0, t};
	endfunction

	assign first = i_start && !busy_q;
	assign div_sel = first ? i_divisor : div_q;
	// 2^24 has only its top bit set, so later dividend bits are zero
	assign step = div_step(first ? 25'd0 : rem_q, first, div_sel);

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (first) begin
				busy_q <= 1'b1;
				cnt_q <= 5'd1;
			end else if (busy_q) begin
				cnt_q <= cnt_q + 5'd1;
				if (cnt_q == 5'(ITERS - 1)) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (first || busy_q) begin
			rem_q <= step[24:0];
			quot_q <= {quot_q[23:0], step[25]};
		end
		if (first)
			div_q <= i_divisor;
	end

	assign o_busy = busy_q;
	assign o_done = done_q;
	assign o_quot = (quot_q[24:23] != 2'b00) ? fx_t'(24'h7fffff) : fx_t'(quot_q[23:0]); // saturate

	// the inverse only starts a division for a positive determinant
	assert property (@(posedge i) disable iff (!i_arst_n) first |-> i_divisor > 0)
		else $error("recip_div: non-positive divisor at start");

endmodule

`default_nettype wire

//--- src/dls_inverse.sv
// 2x2 inverse through determinant and reciprocal
// flags det <= 0 as singular and returns a zero inverse
`default_nettype none

module dls_inverse (
	input wire logic i,
	input wire logic i_arst_n,
	input wire logic i_start,
	input wire ik_pkg::mat2_t i_a,
	output logic o_busy,
	output logic o_done,
	output logic o_singular,
	output ik_pkg::mat2_t o_inv
);
	import ik_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_CHECK, S_WAIT} state_t;

	state_t state_q;
	mat2_t a_q;
	fx_t det_q;
	logic div_start;
	logic div_done;
	fx_t quot;

	assign o_busy = (state_q != S_IDLE);
	assign div_start = (state_q == S_CHECK) && (det_q > 0);

	recip_div recip_div_inst (
		.i(i),
		.i_arst_n(i_arst_n),
		.i_start(div_start),
		.i_divisor(det_q),
		.o_busy(),
		.o_done(div_done),
		.o_quot(quot)
	);

	// matrix and determinant captured on start
	always_ff @(posedge i) begin
		if (i_start && state_q == S_IDLE) begin
			a_q <= i_a;
			det_q <= fx_mul(i_a.m00, i_a.m11) - fx_mul(i_a.m01, i_a.m10);
		end
	end

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= S_IDLE;
			o_done <= 1'b0;
			o_singular <= 1'b0;
			o_inv <= '0;
		end else begin
			o_done <= 1'b0;
			case (state_q)
				S_IDLE: if (i_start) state_q <= S_CHECK;
				S_CHECK: begin
					if (det_q > 0) begin
						state_q <= S_WAIT; // divider started this cycle
					end else begin
						state_q <= S_IDLE;
						o_done <= 1'b1;
						o_singular <= 1'b1;
						o_inv <= '0;
					end
				end
				S_WAIT: begin
					if (div_done) begin
						// adjugate times 1/det
						o_inv.m00 <= fx_mul(a_q.m11, quot);
						o_inv.m01 <= fx_mul(-a_q.m01, quot);
						o_inv.m10 <= fx_mul(-a_q.m10, quot);
						o_inv.m11 <= fx_mul(a_q.m00, quot);
						o_singular <= 1'b0;
						o_done <= 1'b1;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/ik_step.sv
// damped least-squares IK step for a planar two-joint arm
// sequences trig, kinematics, shared multiplier and inverse, writes back angles
`default_nettype none

module ik_step #(
	parameter ik_pkg::fx_t LINK1 = 24'sd4096,
	parameter ik_pkg::fx_t LINK2 = 24'sd3072,
	parameter ik_pkg::fx_t DAMPING = 24'sd410
) (
	input wire logic i,
	input wire logic i_arst_n,
	input wire logic i_start,
	input wire ik_pkg::joint_angles_t i_theta,
	input wire ik_pkg::vec2_t i_target,
	output ik_pkg::joint_angles_t o_theta,
	output ik_pkg::vec2_t o_pos,
	output logic o_busy,
	output logic o_done,
	output logic o_singular
);
	import ik_pkg::*;

	typedef enum logic [2:0] {
		IDLE, TRIG, KIN, JJT, INV, SOLVE_W, SOLVE_D, UPDATE
	} state_t;

	localparam int INV_CYCLES = 28; // inverse latency, singular or not

	state_t state_q;
	logic [4:0] inv_cnt_q;
	logic inv_last;
	logic inv_start;
	logic inv_done;
	logic inv_singular;
	logic solving;
	joint_angles_t theta_q;
	vec2_t target_q;
	trig_t trig;
	vec2_t pos;
	vec2_t err;
	mat2_t jac;
	mat2_t jac_t;
	mat2_t prod;
	mat2_t mul_a;
	mat2_t mul_b;
	mat2_t a_damped;
	mat2_t a_inv;
	angle_t d1;
	angle_t d2;

	sincos_lut sincos_lut_inst (
		.i(i),
		.i_arst_n(i_arst_n),
		.i_theta(theta_q),
		.o_trig(trig)
	);

	arm_kinematics #(
		.LINK1(LINK1),
		.LINK2(LINK2)
	) arm_kinematics_inst (
		.i(i),
		.i_arst_n(i_arst_n),
		.i_trig(trig),
		.o_pos(pos),
		.o_jac(jac)
	);

	mat_mult2 mat_mult2_inst (
		.i(i),
		.i_arst_n(i_arst_n),
		.i_check(solving),
		.i_a(mul_a),
		.i_b(mul_b),
		.o_p(prod)
	);

	dls_inverse dls_inverse_inst (
		.i(i),
		.i_arst_n(i_arst_n),
		.i_start(inv_start),
		.i_a(a_damped),
		.o_busy(),
		.o_done(inv_done),
		.o_singular(inv_singular),
		.o_inv(a_inv)
	);

	assign o_busy = (state_q != IDLE);
	assign inv_last = (inv_cnt_q == 5'(INV_CYCLES - 1));
	assign inv_start = (state_q == INV) && (inv_cnt_q == 5'd0);
	assign solving = (state_q == SOLVE_W) || (state_q == SOLVE_D);

	assign err.x = target_q.x - pos.x; // e = target - position
	assign err.y = target_q.y - pos.y;

	always_comb begin
		jac_t = '{m00: jac.m00, m01: jac.m10, m10: jac.m01, m11: jac.m11};
		a_damped = prod; // J*J' sits in prod during the first INV cycle
		a_damped.m00 = prod.m00 + DAMPING;
		a_damped.m11 = prod.m11 + DAMPING;
		mul_a = jac;
		mul_b = jac_t;
		case (state_q)
			SOLVE_W: begin
				mul_a = a_inv;
				mul_b = '{m00: err.x, m01: '0, m10: err.y, m11: '0};
			end
			SOLVE_D: begin
				mul_a = jac_t;
				mul_b = '{m00: prod.m00, m01: '0, m10: prod.m10, m11: '0}; // w column
			end
			default: ;
		endcase
	end

	// radians to angle units, low 12 bits wrap
	assign d1 = angle_t'(fx_mul(prod.m00, RAD_TO_ANG));
	assign d2 = angle_t'(fx_mul(prod.m10, RAD_TO_ANG));

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= IDLE;
			inv_cnt_q <= '0;
		end else begin
			case (state_q)
				IDLE: if (i_start) state_q <= TRIG;
				TRIG: state_q <= KIN;
				KIN: state_q <= JJT;
				JJT: begin
					state_q <= INV;
					inv_cnt_q <= '0;
				end
				INV: begin
					inv_cnt_q <= inv_cnt_q + 5'd1;
					if (inv_last)
						state_q <= SOLVE_W;
				end
				SOLVE_W: state_q <= SOLVE_D;
				SOLVE_D: state_q <= UPDATE;
				UPDATE: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (i_start && state_q == IDLE) begin
			theta_q <= i_theta;
			target_q <= i_target;
		end
	end

	always_ff @(posedge i or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_theta <= '0;
			o_pos <= '0;
			o_done <= 1'b0;
			o_singular <= 1'b0;
		end else begin
			o_done <= (state_q == UPDATE);
			if (state_q == UPDATE) begin
				o_pos <= pos;
				o_singular <= inv_singular;
				if (inv_singular) begin
					o_theta <= theta_q; // no step on a singular A
				end else begin
					o_theta.t1 <= theta_q.t1 + d1;
					o_theta.t2 <= theta_q.t2 + d2;
				end
			end
		end
	end

	assert property (@(posedge i) disable iff (!i_arst_n) DAMPING >= 24'sd205)
		else $error("ik_step: damping below 205");

	// inverse must have reported by the fixed end of INV
	assert property (@(posedge i) disable iff (!i_arst_n)
		state_q == INV && inv_last |-> inv_done || inv_singular)
		else $error("ik_step: inverse not ready at end of INV");

	assert property (@(posedge i) disable iff (!i_arst_n)
		i_start && !o_busy |-> ##35 o_done)
		else $error("ik_step: start-to-done latency is not 35 cycles");

endmodule

`default_nettype wire

//--- dv/ik_step_tb.sv
// testbench for the IK step engine
// LFSR stimulus checked against a bit-exact fixed-point model
`default_nettype none

module ik_step_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import ik_pkg::*;

	`include "sine_table.svh"

	localparam fx_t LINK1 = 24'sd4096;
	localparam fx_t LINK2 = 24'sd3072;
	localparam fx_t DAMPING = 24'sd410;
	localparam int RUNS = 40 + 4 + 16 + 1 + 8;
	localparam int CYCLE_LIMIT = RUNS * 40 * 2;

	typedef struct packed {
		joint_angles_t theta;
		vec2_t pos;
		logic singular;
	} step_result_t;

	typedef struct packed {
		vec2_t pos;
		mat2_t jac;
	} kin_t;

	logic clk;
	logic arst_n;
	logic start;
	joint_angles_t theta_in;
	vec2_t target_in;
	joint_angles_t theta_out;
	vec2_t pos_out;
	logic busy;
	logic done;
	logic singular;

	logic [15:0] lfsr_q = 16'd77;
	int checks = 0;
	int errors = 0;
	int cycle_cnt = 0;

	ik_step #(
		.LINK1(LINK1),
		.LINK2(LINK2),
		.DAMPING(DAMPING)
	) ik_step_inst (
		.i(clk),
		.i_arst_n(arst_n),
		.i_start(start),
		.i_theta(theta_in),
		.i_target(target_in),
		.o_theta(theta_out),
		.o_pos(pos_out),
		.o_busy(busy),
		.o_done(done),
		.o_singular(singular)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic joint_angles_t random_angles();
		joint_angles_t th;
		th.t1 = angle_t'(rand_bits(12));
		th.t2 = angle_t'(rand_bits(12));
		return th;
	endfunction

	// rejection sampling inside radius 1.5
	function automatic vec2_t random_target();
		vec2_t t;
		longint x;
		longint y;
		do begin
			x = longint'(rand_bits(14)) - 8192;
			y = longint'(rand_bits(14)) - 8192;
		end while (x * x + y * y > 6144 * 6144);
		t.x = fx_t'(x);
		t.y = fx_t'(y);
		return t;
	endfunction

	function automatic fx_t table_sin(input angle_t a);
		int n;
		int m;
		fx_t v;
		n = a[11:4];
		m = n % 128;
		if (m > 64)
			m = 128 - m; // mirrored second quadrant
		v = fx_t'(SINE_TABLE[m]);
		if (n >= 128)
			v = -v;
		return v;
	endfunction

	function automatic fx_t mul_fx(input fx_t a, input fx_t b);
		longint p;
		p = longint'(a) * longint'(b);
		p = p >>> FRAC;
		return fx_t'(p[23:0]);
	endfunction

	function automatic mat2_t mat_mul(input mat2_t a, input mat2_t b);
		mat2_t p;
		p.m00 = mul_fx(a.m00, b.m00) + mul_fx(a.m01, b.m10);
		p.m01 = mul_fx(a.m00, b.m01) + mul_fx(a.m01, b.m11);
		p.m10 = mul_fx(a.m10, b.m00) + mul_fx(a.m11, b.m10);
		p.m11 = mul_fx(a.m10, b.m01) + mul_fx(a.m11, b.m11);
		return p;
	endfunction

	function automatic kin_t forward_kin(input joint_angles_t th);
		angle_t t12;
		fx_t ax;
		fx_t ay;
		fx_t bx;
		fx_t by;
		kin_t k;
		t12 = th.t1 + th.t2;
		ax = mul_fx(LINK1, table_sin(th.t1 + 12'd1024));
		ay = mul_fx(LINK1, table_sin(th.t1));
		bx = mul_fx(LINK2, table_sin(t12 + 12'd1024));
		by = mul_fx(LINK2, table_sin(t12));
		k.pos.x = ax + bx;
		k.pos.y = ay + by;
		k.jac.m00 = -ay - by;
		k.jac.m01 = -by;
		k.jac.m10 = ax + bx;
		k.jac.m11 = bx;
		return k;
	endfunction

	// 2^24 / d truncated toward zero and saturated to the largest fx_t
	function automatic fx_t recip(input fx_t d);
		longint q;
		q = (longint'(1) << 24) / longint'(d);
		if (q > 64'sd8388607)
			q = 64'sd8388607;
		return fx_t'(q[23:0]);
	endfunction

	function automatic step_result_t model_step(input joint_angles_t th, input vec2_t tg);
		kin_t k;
		mat2_t jt;
		mat2_t a;
		mat2_t inv;
		mat2_t w;
		mat2_t d;
		fx_t det;
		fx_t q;
		fx_t na01;
		fx_t na10;
		fx_t ex;
		fx_t ey;
		fx_t s1;
		fx_t s2;
		step_result_t r;
		k = forward_kin(th);
		jt = '{m00: k.jac.m00, m01: k.jac.m10, m10: k.jac.m01, m11: k.jac.m11};
		a = mat_mul(k.jac, jt);
		a.m00 = a.m00 + DAMPING; // lambda^2 on the diagonal
		a.m11 = a.m11 + DAMPING;
		det = mul_fx(a.m00, a.m11) - mul_fx(a.m01, a.m10);
		r.pos = k.pos;
		r.theta = th;
		r.singular = (det <= 0);
		if (det > 0) begin
			q = recip(det);
			na01 = -a.m01;
			na10 = -a.m10;
			inv = '{m00: mul_fx(a.m11, q), m01: mul_fx(na01, q),
				m10: mul_fx(na10, q), m11: mul_fx(a.m00, q)};
			ex = tg.x - k.pos.x;
			ey = tg.y - k.pos.y;
			w = mat_mul(inv, '{m00: ex, m01: '0, m10: ey, m11: '0});
			d = mat_mul(jt, '{m00: w.m00, m01: '0, m10: w.m10, m11: '0});
			s1 = mul_fx(d.m00, RAD_TO_ANG); // radians to angle units
			s2 = mul_fx(d.m10, RAD_TO_ANG);
			r.theta.t1 = th.t1 + angle_t'(s1);
			r.theta.t2 = th.t2 + angle_t'(s2);
		end
		return r;
	endfunction

	function automatic int unit_cos(input int q);
		case (q % 4)
			0: return 1;
			2: return -1;
			default: return 0;
		endcase
	endfunction

	// sin(q quarters) is cos(q - 1 quarters)
	function automatic vec2_t quadrant_pos(input int q1, input int q2);
		vec2_t p;
		p.x = fx_t'(LINK1 * unit_cos(q1) + LINK2 * unit_cos(q1 + q2));
		p.y = fx_t'(LINK1 * unit_cos(q1 + 3) + LINK2 * unit_cos(q1 + q2 + 3));
		return p;
	endfunction

	task automatic wait_done();
		do @(negedge clk); while (!done);
	endtask

	task automatic run_step(input joint_angles_t th, input vec2_t tg);
		@(posedge clk);
		start <= 1'b1;
		theta_in <= th;
		target_in <= tg;
		@(posedge clk);
		start <= 1'b0;
		wait_done();
	endtask

	task automatic check_step(input string what, input step_result_t exp);
		checks++;
		assert (theta_out == exp.theta && pos_out == exp.pos && singular == exp.singular)
		else begin
			errors++;
			$write("Error at time %0t: %s got theta %0d/%0d pos %0d/%0d sing %0b",
				$time, what, theta_out.t1, theta_out.t2, pos_out.x, pos_out.y, singular);
			$display(", expected theta %0d/%0d pos %0d/%0d sing %0b",
				exp.theta.t1, exp.theta.t2, exp.pos.x, exp.pos.y, exp.singular);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: finished with %0d errors", name, errors - errs_before);
	endtask

	task automatic check_reset_values();
		int e0;
		e0 = errors;
		checks++;
		assert (!busy && !done && !singular && theta_out == '0 && pos_out == '0)
		else begin
			errors++;
			$display("Error at time %0t: outputs not cleared after reset", $time);
		end
		report_test("reset values", e0);
	endtask

	task automatic random_steps();
		int e0;
		joint_angles_t th;
		vec2_t tg;
		e0 = errors;
		for (int n = 0; n < 40; n++) begin
			th = random_angles();
			tg = random_target();
			run_step(th, tg);
			check_step("random step", model_step(th, tg));
		end
		report_test("random steps", e0);
	endtask

	// target on the arm tip makes the step zero
	task automatic zero_error_steps();
		int e0;
		joint_angles_t th;
		vec2_t tg;
		kin_t k;
		e0 = errors;
		for (int n = 0; n < 4; n++) begin
			th = random_angles();
			k = forward_kin(th);
			tg = k.pos;
			run_step(th, tg);
			check_step("zero error", model_step(th, tg));
			checks++;
			assert (theta_out == th) else begin
				errors++;
				$display("Error at time %0t: angles moved with zero error, %0d/%0d vs %0d/%0d",
					$time, theta_out.t1, theta_out.t2, th.t1, th.t2);
			end
		end
		report_test("zero error steps", e0);
	endtask

	task automatic quadrant_steps();
		int e0;
		joint_angles_t th;
		vec2_t tg;
		vec2_t exact;
		e0 = errors;
		tg = '{x: 24'sd2048, y: 24'sd2048};
		for (int q1 = 0; q1 < 4; q1++) begin
			for (int q2 = 0; q2 < 4; q2++) begin
				th.t1 = angle_t'(q1 * 1024);
				th.t2 = angle_t'(q2 * 1024);
				exact = quadrant_pos(q1, q2);
				run_step(th, tg);
				check_step("quadrant", model_step(th, tg));
				checks++;
				assert (pos_out == exact) else begin
					errors++;
					$display("Error at time %0t: quadrant %0d/%0d pos %0d/%0d, exact %0d/%0d",
						$time, q1, q2, pos_out.x, pos_out.y, exact.x, exact.y);
				end
			end
		end
		report_test("quadrant angles", e0);
	endtask

	task automatic busy_start_ignored();
		int e0;
		int dones;
		joint_angles_t th;
		vec2_t tg;
		e0 = errors;
		dones = 0;
		th = random_angles();
		tg = random_target();
		@(posedge clk);
		start <= 1'b1;
		theta_in <= th;
		target_in <= tg;
		@(posedge clk);
		start <= 1'b0;
		repeat (5) @(posedge clk);
		start <= 1'b1; // second request while busy
		theta_in <= random_angles();
		target_in <= random_target();
		@(negedge clk);
		checks++;
		assert (busy) else begin
			errors++;
			$display("Error at time %0t: o_busy low while the first step runs", $time);
		end
		@(posedge clk);
		start <= 1'b0;
		wait_done();
		dones++;
		check_step("busy start", model_step(th, tg));
		repeat (40) begin
			@(negedge clk);
			if (done)
				dones++;
		end
		checks++;
		assert (dones == 1) else begin
			errors++;
			$display("Error at time %0t: start while busy gave %0d done pulses", $time, dones);
		end
		report_test("start while busy", e0);
	endtask

	task automatic iterate_feedback();
		int e0;
		joint_angles_t th;
		vec2_t tg;
		e0 = errors;
		th = random_angles();
		tg = random_target();
		for (int n = 0; n < 8; n++) begin
			run_step(th, tg);
			check_step("feedback", model_step(th, tg));
			th = theta_out; // next step starts where this one ended
		end
		report_test("feedback iterations", e0);
	endtask

	// run limit from the number of steps
	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		theta_in = '0;
		target_in = '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_reset_values();
		random_steps();
		zero_error_steps();
		quadrant_steps();
		busy_start_ignored();
		iterate_feedback();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ik_step.f
+incdir+include
src/ik_pkg.sv
src/sincos_lut.sv
src/arm_kinematics.sv
src/mat_mult2.sv
src/recip_div.sv
src/dls_inverse.sv
src/ik_step.sv
dv/ik_step_tb.sv
